//--- bench/program_table.svh
//-------------------------------------------------
// program for the rv_core testbench and the stores
// it must produce in program order
// included inside the testbench module
//-------------------------------------------------

`ifndef program_table_svh
`define program_table_svh

localparam int program_len = 24;
localparam int store_count = 10;

typedef struct packed {
  logic [63:0] addr;
  logic [63:0] data;
} store_row_t;

logic [31:0] program_rom [program_len];
store_row_t store_rows [store_count];

task automatic fill_tables();
  // dependent alu chain starting from x1 = 100
  program_rom[0] = imm_op(5'd1, 5'd0, 12'd100);
  program_rom[1] = imm_op(5'd2, 5'd1, 12'd23);
  program_rom[2] = reg_op(7'b0000000, 3'b000, 5'd3, 5'd2, 5'd1);
  program_rom[3] = reg_op(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd2);
  program_rom[4] = reg_op(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd3);
  program_rom[5] = reg_op(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd4);
  program_rom[6] = reg_op(7'b0000000, 3'b100, 5'd7, 5'd6, 5'd3);
  program_rom[7] = store_dword(5'd3, 5'd0, 12'h100);
  program_rom[8] = store_dword(5'd4, 5'd0, 12'h108);
  program_rom[9] = store_dword(5'd5, 5'd0, 12'h110);
  program_rom[10] = store_dword(5'd6, 5'd0, 12'h118);
  program_rom[11] = store_dword(5'd7, 5'd0, 12'h120);
  // negative results and a store at a negative offset from x1
  program_rom[12] = reg_op(7'b0100000, 3'b000, 5'd8, 5'd1, 5'd3);
  program_rom[13] = store_dword(5'd8, 5'd0, 12'h128);
  program_rom[14] = imm_op(5'd9, 5'd8, 12'hffb);
  program_rom[15] = store_dword(5'd9, 5'd1, 12'hff8);
  // load-use on an alu source and then on store data
  program_rom[16] = imm_op(5'd10, 5'd0, 12'h200);
  program_rom[17] = load_dword(5'd11, 5'd10, 12'd8);
  program_rom[18] = reg_op(7'b0000000, 3'b000, 5'd12, 5'd11, 5'd1);
  program_rom[19] = store_dword(5'd12, 5'd10, 12'd0);
  program_rom[20] = load_dword(5'd13, 5'd10, 12'd16);
  program_rom[21] = store_dword(5'd13, 5'd10, 12'd24);
  // write to x0 must not stick
  program_rom[22] = imm_op(5'd0, 5'd1, 12'd55);
  program_rom[23] = store_dword(5'd0, 5'd10, 12'd32);

  store_rows[0] = '{addr: 64'h100, data: 64'hdf};
  store_rows[1] = '{addr: 64'h108, data: 64'h64};
  store_rows[2] = '{addr: 64'h110, data: 64'h44};
  store_rows[3] = '{addr: 64'h118, data: 64'h64};
  store_rows[4] = '{addr: 64'h120, data: 64'hbb};
  store_rows[5] = '{addr: 64'h128, data: 64'hffff_ffff_ffff_ff85};
  store_rows[6] = '{addr: 64'h05c, data: 64'hffff_ffff_ffff_ff80};
  store_rows[7] = '{addr: 64'h200, data: 64'h5a5a_0000_0000_10a0};
  store_rows[8] = '{addr: 64'h218, data: 64'h5a5a_0000_0000_1024};
  store_rows[9] = '{addr: 64'h220, data: 64'h0};
endtask

`endif

//--- bench/rv_core_tb.sv
//-------------------------------------------------
// drives rv_core through the program table
// answers both buses with random ready delays
// and checks every completed store against the table
//-------------------------------------------------

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [63:0] load_pattern = 64'h5a5a_0000_0000_1234;
  // addi x0, x0, 0
  localparam logic [31:0] nop_word = 32'h0000_0013;
  localparam int drain_cycles = 30;

  logic clock = 1'b0;
  logic reset;
  logic imem_valid;
  logic [63:0] imem_addr;
  logic imem_ready = 1'b0;
  logic [31:0] imem_data = 32'h0000_0013;
  logic dmem_valid, dmem_write;
  logic [63:0] dmem_addr, dmem_wdata;
  logic dmem_ready = 1'b0;
  logic [63:0] dmem_rdata = 64'd0;

  logic imem_fired = 1'b0;
  logic dmem_fired = 1'b0;
  logic first_fetch_done = 1'b0;
  logic first_access_done = 1'b0;
  int imem_wait = 0;
  int dmem_wait = 0;
  int stores_seen = 0;
  int cycle_count = 0;

  function automatic logic [31:0] reg_op(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  // addi
  function automatic logic [31:0] imm_op(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] load_dword(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, 3'b011, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] store_dword(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  `include "program_table.svh"

  localparam int timeout_cycles = 20 * program_len + 50;

  rv_core #(.reset_pc(64'd0)) rv_core_inst (
    .clock(clock), .reset(reset),
    .imem_valid(imem_valid), .imem_addr(imem_addr),
    .imem_ready(imem_ready), .imem_data(imem_data),
    .dmem_valid(dmem_valid), .dmem_write(dmem_write),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata)
  );

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s = %h, expected %h", name, actual, expected);
      $display("Test failed");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  // nop past the end of the program
  function automatic logic [31:0] fetch_word(input logic [63:0] addr);
    logic [61:0] index;
    index = addr[63:2];
    if (index < 62'(program_len)) return program_rom[index[4:0]];
    return nop_word;
  endfunction

  task automatic wait_for_store();
    @(posedge clock);
    while (!(dmem_valid && dmem_ready && dmem_write)) @(posedge clock);
  endtask

  initial begin
    forever #5 clock = ~clock;
  end

  // bus activity seen at the rising edge
  always @(posedge clock) begin
    imem_fired = !reset && imem_valid && imem_ready;
    dmem_fired = !reset && dmem_valid && dmem_ready;
    if (dmem_fired && dmem_write) stores_seen++;
    if (!reset && imem_valid && !first_fetch_done) begin
      first_fetch_done = 1'b1;
      compare_value("imem_addr", imem_addr, 64'd0);
    end
    if (!reset && dmem_valid && !first_access_done) begin
      first_access_done = 1'b1;
      compare_value("dmem_write", 64'(dmem_write), 64'd1);
      compare_value("dmem_addr", dmem_addr, store_rows[0].addr);
    end
  end

  // both responders draw a new delay after each transfer
  always @(negedge clock) begin
    if (imem_fired) imem_wait = int'($urandom % 4);
    if (dmem_fired) dmem_wait = int'($urandom % 4);
    imem_ready = (imem_wait == 0);
    dmem_ready = (dmem_wait == 0);
    if (imem_wait != 0) imem_wait--;
    if (dmem_wait != 0) dmem_wait--;
    imem_data = fetch_word(imem_addr);
    dmem_rdata = dmem_addr ^ load_pattern;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timed out after %0d cycles with %0d of %0d stores done",
               cycle_count, stores_seen, store_count);
      $display("Test failed");
      $fatal(1, "no progress before the cycle limit");
    end
  end

  initial begin
    int row;
    void'($urandom(32'he255));
    reset = 1'b1;
    fill_tables();
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    for (row = 0; row < store_count; row++) begin
      wait_for_store();
      compare_value("dmem_addr", dmem_addr, store_rows[row].addr);
      compare_value("dmem_wdata", dmem_wdata, store_rows[row].data);
    end

    // nothing more may be stored
    repeat (drain_cycles) @(posedge clock);
    @(negedge clock);
    compare_value("store count", 64'(stores_seen), 64'(store_count));
    $display("Test passed");
    $finish;
  end

endmodule

//--- common/rv_core_pkg.sv
//-------------------------------------------------
// shared widths, opcodes and ALU codes for rv_core
// also the instruction word union read by decode
//-------------------------------------------------

package rv_core_pkg;

  localparam int xlen = 64;
  localparam int reg_addr_width = 5;
  localparam int inst_width = 32;
  localparam int alu_op_width = 3;

  // major opcodes kept in the subset
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_or = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  localparam logic [alu_op_width-1:0] alu_add = 3'd0;
  localparam logic [alu_op_width-1:0] alu_sub = 3'd1;
  localparam logic [alu_op_width-1:0] alu_and = 3'd2;
  localparam logic [alu_op_width-1:0] alu_or = 3'd3;
  localparam logic [alu_op_width-1:0] alu_xor = 3'd4;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  // one word, three ways to read it
  typedef union packed {
    r_view_t r;
    i_view_t i;
    s_view_t s;
  } inst_t;

endpackage

//--- common/stage_links.sv
//-------------------------------------------------
// handshaked links between pipeline stages
// an item moves when valid and ready are both high
//-------------------------------------------------

interface issue_link;
  import rv_core_pkg::*;

  logic valid, ready;
  logic [alu_op_width-1:0] alu_op;
  logic [xlen-1:0] op_a, op_b, store_data;
  logic [reg_addr_width-1:0] rs1, rs2, dest;
  logic use_rs1, use_rs2, write_reg, is_load, is_store;

  modport decode (
    output valid, alu_op, op_a, op_b, rs1, rs2, use_rs1, use_rs2,
    output dest, write_reg, is_load, is_store, store_data,
    input ready
  );
  modport execute (
    input valid, alu_op, op_a, op_b, rs1, rs2, use_rs1, use_rs2,
    input dest, write_reg, is_load, is_store, store_data,
    output ready
  );
endinterface

interface mem_link;
  import rv_core_pkg::*;

  logic valid, ready, write_reg, is_load, is_store;
  logic [reg_addr_width-1:0] dest;
  // alu result, or the address for loads and stores
  logic [xlen-1:0] value, store_data;

  modport execute (output valid, dest, write_reg, is_load, is_store, value, store_data,
                   input ready);
  modport memory (input valid, dest, write_reg, is_load, is_store, value, store_data,
                  output ready);
endinterface

//--- decode/decode_stage.sv
//-------------------------------------------------
// instruction decode and register read
// fills the decode/execute register on issue_link
//-------------------------------------------------

module decode_stage (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   fetch_valid,
  input  logic [rv_core_pkg::inst_width-1:0]     fetch_inst,
  output logic                                   decode_ready,
  output logic [rv_core_pkg::reg_addr_width-1:0] rs1_addr,
  output logic [rv_core_pkg::reg_addr_width-1:0] rs2_addr,
  input  logic [rv_core_pkg::xlen-1:0]           rs1_data,
  input  logic [rv_core_pkg::xlen-1:0]           rs2_data,
  issue_link.decode                              issue
);
  import rv_core_pkg::*;

  inst_t inst;
  logic [xlen-1:0] imm_i, imm_s;
  logic [alu_op_width-1:0] alu_op;
  logic is_op, is_op_imm, is_load, is_store;
  logic take;

  assign inst = fetch_inst;
  assign is_op = inst.r.opcode == opcode_op;
  assign is_op_imm = inst.i.opcode == opcode_op_imm;
  assign is_load = inst.i.opcode == opcode_load;
  assign is_store = inst.s.opcode == opcode_store;

  assign imm_i = {{(xlen - 12){inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{(xlen - 12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};

  // loads and stores fall through to add for the address
  always_comb begin
    alu_op = alu_add;
    if (is_op || is_op_imm) begin
      case (inst.r.funct3)
        funct3_add: alu_op = (is_op && inst.r.funct7[5]) ? alu_sub : alu_add;
        funct3_xor: alu_op = alu_xor;
        funct3_or:  alu_op = alu_or;
        funct3_and: alu_op = alu_and;
        default:    alu_op = alu_add;
      endcase
    end
  end

  assign decode_ready = !issue.valid || issue.ready;
  assign take = fetch_valid && decode_ready;

  // a held item keeps reading its own sources
  assign rs1_addr = decode_ready ? inst.r.rs1 : issue.rs1;
  assign rs2_addr = decode_ready ? inst.r.rs2 : issue.rs2;

  always_ff @(posedge clock) begin
    if (reset) begin
      issue.valid <= 1'b0;
    end else if (decode_ready) begin
      issue.valid <= fetch_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      issue.alu_op <= alu_op;
      issue.op_a <= rs1_data;
      issue.op_b <= is_op ? rs2_data : (is_store ? imm_s : imm_i);
      issue.store_data <= rs2_data;
      issue.rs1 <= inst.r.rs1;
      issue.rs2 <= inst.r.rs2;
      issue.use_rs1 <= is_op || is_op_imm || is_load || is_store;
      issue.use_rs2 <= is_op || is_store;
      issue.dest <= inst.r.rd;
      issue.write_reg <= (is_op || is_op_imm || is_load) && inst.r.rd != '0;
      issue.is_load <= is_load;
      issue.is_store <= is_store;
    end else if (!decode_ready) begin
      // picks up writes that retired while stalled
      issue.op_a <= rs1_data;
      issue.store_data <= rs2_data;
    end
  end

endmodule

//--- decode/register_file.sv
//-------------------------------------------------
// 32 x 64-bit integer registers, two read ports
// x0 reads zero, same-cycle write bypasses to reads
//-------------------------------------------------

module register_file (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic [rv_core_pkg::reg_addr_width-1:0] rs1_addr,
  input  logic [rv_core_pkg::reg_addr_width-1:0] rs2_addr,
  output logic [rv_core_pkg::xlen-1:0]           rs1_data,
  output logic [rv_core_pkg::xlen-1:0]           rs2_data,
  input  logic                                   wb_valid,
  input  logic [rv_core_pkg::reg_addr_width-1:0] wb_dest,
  input  logic [rv_core_pkg::xlen-1:0]           wb_data
);
  import rv_core_pkg::*;

  logic [xlen-1:0] regs [32];

  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_width-1:0] addr);
    if (addr == '0) return '0;
    if (wb_valid && wb_dest == addr) return wb_data;
    return regs[addr];
  endfunction

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

  always_ff @(posedge clock) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wb_valid && wb_dest != '0) begin
      regs[wb_dest] <= wb_data;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the rv_core testbench with Verilator and runs it
# a failing bench ends in $fatal, so the exit status carries the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module rv_core_tb \
  -f rv_core.f \
  -o rv_core_sim

./obj_dir/rv_core_sim

//--- rv_core.f
+incdir+bench
common/rv_core_pkg.sv
common/stage_links.sv
verilog/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/rv_core.sv
bench/rv_core_tb.sv

//--- verilog/execute_stage.sv
//-------------------------------------------------
// operand forwarding, load-use hold and the ALU
// result goes to the execute/memory register
//-------------------------------------------------

module execute_stage (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   wb_valid,
  input  logic [rv_core_pkg::reg_addr_width-1:0] wb_dest,
  input  logic [rv_core_pkg::xlen-1:0]           wb_data,
  issue_link.execute                             issue,
  mem_link.execute                               mem
);
  import rv_core_pkg::*;

  logic ex_valid, ex_write_reg, ex_is_load, ex_is_store;
  logic [reg_addr_width-1:0] ex_dest;
  logic [xlen-1:0] ex_value, ex_store_data;
  logic load_use, advance, accept;
  logic [xlen-1:0] rs1_value, rs2_value, alu_a, alu_b, alu_result;

  // youngest producer wins, a load result is not ready yet
  function automatic logic [xlen-1:0] forward(input logic [reg_addr_width-1:0] src,
                                              input logic [xlen-1:0] issued);
    if (src == '0) return issued;
    if (ex_valid && ex_write_reg && !ex_is_load && ex_dest == src) return ex_value;
    if (wb_valid && wb_dest == src) return wb_data;
    return issued;
  endfunction

  assign rs1_value = forward(issue.rs1, issue.op_a);
  assign rs2_value = forward(issue.rs2, issue.store_data);
  assign alu_a = issue.use_rs1 ? rs1_value : issue.op_a;
  assign alu_b = (issue.use_rs2 && !issue.is_store) ? rs2_value : issue.op_b;

  assign load_use = ex_valid && ex_is_load && ex_write_reg &&
                    ((issue.use_rs1 && issue.rs1 == ex_dest) ||
                     (issue.use_rs2 && issue.rs2 == ex_dest));

  assign advance = !ex_valid || mem.ready;
  assign issue.ready = advance && !load_use;
  assign accept = issue.valid && issue.ready;

  always_comb begin
    case (issue.alu_op)
      alu_sub: alu_result = alu_a - alu_b;
      alu_and: alu_result = alu_a & alu_b;
      alu_or:  alu_result = alu_a | alu_b;
      alu_xor: alu_result = alu_a ^ alu_b;
      default: alu_result = alu_a + alu_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (advance) begin
      ex_valid <= issue.valid && !load_use;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      ex_dest <= issue.dest;
      ex_write_reg <= issue.write_reg;
      ex_is_load <= issue.is_load;
      ex_is_store <= issue.is_store;
      ex_value <= alu_result;
      ex_store_data <= rs2_value;
    end
  end

  assign mem.valid = ex_valid;
  assign mem.dest = ex_dest;
  assign mem.write_reg = ex_write_reg;
  assign mem.is_load = ex_is_load;
  assign mem.is_store = ex_is_store;
  assign mem.value = ex_value;
  assign mem.store_data = ex_store_data;

endmodule

//--- verilog/fetch_stage.sv
//-------------------------------------------------
// program counter and instruction fetch
// one request at a time, word lands in fetch/decode reg
//-------------------------------------------------

module fetch_stage #(
  parameter logic [rv_core_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                               clock,
  input  logic                               reset,
  output logic                               imem_valid,
  output logic [rv_core_pkg::xlen-1:0]       imem_addr,
  input  logic                               imem_ready,
  input  logic [rv_core_pkg::inst_width-1:0] imem_data,
  output logic                               fetch_valid,
  output logic [rv_core_pkg::inst_width-1:0] fetch_inst,
  input  logic                               decode_ready
);

  logic running;
  logic handshake;

  // once raised, the slot stays free until the word arrives
  assign imem_valid = running && (!fetch_valid || decode_ready);
  assign handshake = imem_valid && imem_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      running <= 1'b0;
      imem_addr <= reset_pc;
      fetch_valid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (handshake) begin
        imem_addr <= imem_addr + 64'd4;
        fetch_valid <= 1'b1;
      end else if (decode_ready) begin
        fetch_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (handshake) begin
      fetch_inst <= imem_data;
    end
  end

endmodule

//--- verilog/memory_stage.sv
//-------------------------------------------------
// data bus access and the write-back register
// loads and stores wait for dmem_ready
//-------------------------------------------------

module memory_stage (
  input  logic                                   clock,
  input  logic                                   reset,
  output logic                                   dmem_valid,
  output logic                                   dmem_write,
  output logic [rv_core_pkg::xlen-1:0]           dmem_addr,
  output logic [rv_core_pkg::xlen-1:0]           dmem_wdata,
  input  logic                                   dmem_ready,
  input  logic [rv_core_pkg::xlen-1:0]           dmem_rdata,
  output logic                                   wb_valid,
  output logic [rv_core_pkg::reg_addr_width-1:0] wb_dest,
  output logic [rv_core_pkg::xlen-1:0]           wb_data,
  mem_link.memory                                mem
);

  logic is_access;
  logic done;

  assign is_access = mem.is_load || mem.is_store;

  // bus fields come straight from the held execute/memory register
  assign dmem_valid = mem.valid && is_access;
  assign dmem_write = mem.is_store;
  assign dmem_addr = mem.value;
  assign dmem_wdata = mem.store_data;

  assign mem.ready = !is_access || dmem_ready;
  assign done = mem.valid && mem.ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= done && mem.write_reg;
    end
  end

  always_ff @(posedge clock) begin
    if (done) begin
      wb_dest <= mem.dest;
      wb_data <= mem.is_load ? dmem_rdata : mem.value;
    end
  end

endmodule

//--- verilog/rv_core.sv
//-------------------------------------------------
// five-stage rv64 integer core, top level
// instruction and data buses are valid/ready ports
//-------------------------------------------------

module rv_core #(
  parameter logic [rv_core_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                                 clock,
  input  logic                                 reset,
  output logic                                 imem_valid,
  output logic [rv_core_pkg::xlen-1:0]         imem_addr,
  input  logic                                 imem_ready,
  input  logic [rv_core_pkg::inst_width-1:0]   imem_data,
  output logic                                 dmem_valid,
  output logic                                 dmem_write,
  output logic [rv_core_pkg::xlen-1:0]         dmem_addr,
  output logic [rv_core_pkg::xlen-1:0]         dmem_wdata,
  input  logic                                 dmem_ready,
  input  logic [rv_core_pkg::xlen-1:0]         dmem_rdata
);
  import rv_core_pkg::*;

  logic fetch_valid, decode_ready;
  logic [inst_width-1:0] fetch_inst;
  logic [reg_addr_width-1:0] rs1_addr, rs2_addr, wb_dest;
  logic [xlen-1:0] rs1_data, rs2_data, wb_data;
  logic wb_valid;

  issue_link issue_if ();
  mem_link mem_if ();

  fetch_stage #(.reset_pc(reset_pc)) fetch_inst_u (
    .clock(clock), .reset(reset),
    .imem_valid(imem_valid), .imem_addr(imem_addr),
    .imem_ready(imem_ready), .imem_data(imem_data),
    .fetch_valid(fetch_valid), .fetch_inst(fetch_inst), .decode_ready(decode_ready)
  );

  decode_stage decode_u (
    .clock(clock), .reset(reset),
    .fetch_valid(fetch_valid), .fetch_inst(fetch_inst), .decode_ready(decode_ready),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .issue(issue_if.decode)
  );

  register_file regs_u (
    .clock(clock), .reset(reset),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
  );

  execute_stage execute_u (
    .clock(clock), .reset(reset),
    .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
    .issue(issue_if.execute), .mem(mem_if.execute)
  );

  memory_stage memory_u (
    .clock(clock), .reset(reset),
    .dmem_valid(dmem_valid), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata),
    .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
    .mem(mem_if.memory)
  );

endmodule
